//--- verilog/calc_pkg.sv
// **************************************************
// Shared encodings and constants for the calculator
// Completion stage indices assume single issue with
// fixed pipe latencies of one and two cycles
// **************************************************

package calc_pkg;

  // Operation codes for the execution pipes
  typedef enum logic [3:0]
  {
    e_op_add  = 4'h0
    , e_op_sub  = 4'h1
    , e_op_and  = 4'h2
    , e_op_or   = 4'h3
    , e_op_xor  = 4'h4
    , e_op_sll  = 4'h5
    , e_op_srl  = 4'h6
    , e_op_sra  = 4'h7
    // Signed and unsigned set-less-than
    , e_op_slt  = 4'h8
    , e_op_sltu = 4'h9
    // Only op routed to the multiply pipe
    , e_op_mul  = 4'ha
  } calc_op_e;

  // 32 integer registers
  localparam int reg_addr_width_gp = 5;

  // Depth of the completion pipe
  localparam int pipe_stage_els_gp = 2;

  // Stage where each pipe merges its result
  localparam int int_comp_idx_gp = 0;
  localparam int mul_comp_idx_gp = 1;

  // Forwarding sources with the youngest at index 0
  // Reservation entry, stage 1 next value, stage 1 at writeback
  localparam int fwd_els_gp = 3;

endpackage

//--- verilog/calc_issue.sv
// **************************************************
// Operand forwarding and reservation register
// A consumer of a multiply must not follow it in the
// next cycle since that product is not forwarded yet
// Flush or poison at dispatch loads a dead entry
// **************************************************
`timescale 1ns/10ps

module calc_issue
  #(parameter data_width_p = 64)
  (input                                                    clk_i
  , input                                                  rst_n_i
  , input                                                  dispatch_v_i
  , input                                                  poison_i
  , input                                                  flush_i
  , input  calc_pkg::calc_op_e                             fu_op_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]               rs1_addr_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]               rs2_addr_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]               rd_addr_i
  , input  [data_width_p-1:0]                              rs1_data_i
  , input  [data_width_p-1:0]                              rs2_data_i
  , input  [data_width_p-1:0]                              imm_i
  , input                                                  use_imm_i
  , input                                                  irf_w_v_i
  , input  [calc_pkg::fwd_els_gp-1:0]                      fwd_w_v_i
  , input  [calc_pkg::fwd_els_gp-1:0][calc_pkg::reg_addr_width_gp-1:0] fwd_rd_addr_i
  , input  [calc_pkg::fwd_els_gp-1:0][data_width_p-1:0]    fwd_data_i
  , output logic                                           res_v_o
  , output logic                                           res_int_v_o
  , output logic                                           res_mul_v_o
  , output calc_pkg::calc_op_e                             res_op_o
  , output logic [data_width_p-1:0]                        res_rs1_o
  , output logic [data_width_p-1:0]                        res_rs2_o
  , output logic [calc_pkg::reg_addr_width_gp-1:0]         res_rd_addr_o
  , output logic                                           res_w_v_o
  , output logic                                           res_poison_o
  , output logic                                           ex1_v_o
  );

  import calc_pkg::*;

  logic [data_width_p-1:0] bypass_rs1;
  logic [data_width_p-1:0] bypass_rs2;
  logic                    kill;
  logic                    load_v;
  logic                    is_mul;

  // Scan oldest to youngest so the youngest match wins
  always_comb
  begin
    bypass_rs1 = rs1_data_i;
    bypass_rs2 = rs2_data_i;
    for (int i = fwd_els_gp-1; i >= 0; i--)
    begin
      if (fwd_w_v_i[i] && (fwd_rd_addr_i[i] == rs1_addr_i))
        bypass_rs1 = fwd_data_i[i];
      if (fwd_w_v_i[i] && (fwd_rd_addr_i[i] == rs2_addr_i))
        bypass_rs2 = fwd_data_i[i];
    end
  end

  assign kill   = flush_i | poison_i;
  assign load_v = dispatch_v_i & ~kill;
  assign is_mul = (fu_op_i == e_op_mul);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      res_v_o      <= 1'b0;
      res_int_v_o  <= 1'b0;
      res_mul_v_o  <= 1'b0;
      res_poison_o <= 1'b0;
    end
    else
    begin
      res_v_o      <= load_v;
      res_int_v_o  <= load_v & ~is_mul;
      res_mul_v_o  <= load_v & is_mul;
      res_poison_o <= dispatch_v_i & kill;
    end
  end

  // Payload where x0 never writes
  always_ff @(posedge clk_i)
  begin
    res_op_o      <= fu_op_i;
    res_rs1_o     <= bypass_rs1;
    res_rs2_o     <= use_imm_i ? imm_i : bypass_rs2;
    res_rd_addr_o <= rd_addr_i;
    res_w_v_o     <= irf_w_v_i & (rd_addr_i != '0);
  end

  // Live in EX1 unless a flush arrives this cycle
  assign ex1_v_o = res_v_o & ~flush_i;

endmodule

//--- verilog/calc_pipe_int.sv
// **************************************************
// Single-cycle integer ALU, purely combinational
// Shift amount is log2(data_width_p) bits of rs2
// Non-integer ops return zero
// **************************************************
`timescale 1ns/10ps

module calc_pipe_int
  #(parameter data_width_p = 64)
  (input  calc_pkg::calc_op_e       op_i
  , input  [data_width_p-1:0]       rs1_i
  , input  [data_width_p-1:0]       rs2_i
  , output logic [data_width_p-1:0] data_o
  );

  import calc_pkg::*;

  localparam int shamt_width_lp = $clog2(data_width_p);

  logic [shamt_width_lp-1:0] shamt;
  logic                      lt_s;
  logic                      lt_u;

  assign shamt = rs2_i[shamt_width_lp-1:0];
  assign lt_s  = ($signed(rs1_i) < $signed(rs2_i));
  assign lt_u  = (rs1_i < rs2_i);

  always_comb
  begin
    case (op_i)
      e_op_add:  data_o = rs1_i + rs2_i;
      e_op_sub:  data_o = rs1_i - rs2_i;
      e_op_and:  data_o = rs1_i & rs2_i;
      e_op_or:   data_o = rs1_i | rs2_i;
      e_op_xor:  data_o = rs1_i ^ rs2_i;
      e_op_sll:  data_o = rs1_i << shamt;
      e_op_srl:  data_o = rs1_i >> shamt;
      // Arithmetic shift keeps the sign
      e_op_sra:  data_o = $signed(rs1_i) >>> shamt;
      e_op_slt:  data_o = {{(data_width_p-1){1'b0}}, lt_s};
      e_op_sltu: data_o = {{(data_width_p-1){1'b0}}, lt_u};
      default:   data_o = '0;
    endcase
  end

endmodule

//--- verilog/calc_pipe_mul.sv
// **************************************************
// Pipelined multiplier, low product word only
// Partial products registered at the end of EX1,
// summed in EX2; accepts a new pair every cycle
// data_width_p must be even
// **************************************************
`timescale 1ns/10ps

module calc_pipe_mul
  #(parameter data_width_p = 64)
  (input                      clk_i
  , input  [data_width_p-1:0] rs1_i
  , input  [data_width_p-1:0] rs2_i
  , output [data_width_p-1:0] data_o
  );

  localparam int half_lp = data_width_p / 2;

  logic [half_lp-1:0]      a_lo;
  logic [half_lp-1:0]      a_hi;
  logic [half_lp-1:0]      b_lo;
  logic [half_lp-1:0]      b_hi;
  logic [data_width_p-1:0] lo_lo_n;
  logic [half_lp-1:0]      cross_n;
  logic [data_width_p-1:0] lo_lo_r;
  logic [half_lp-1:0]      cross_r;

  assign a_lo = rs1_i[half_lp-1:0];
  assign a_hi = rs1_i[data_width_p-1:half_lp];
  assign b_lo = rs2_i[half_lp-1:0];
  assign b_hi = rs2_i[data_width_p-1:half_lp];

  // hi*hi lands above the low word and is dropped
  assign lo_lo_n = a_lo * b_lo;
  assign cross_n = a_lo * b_hi + a_hi * b_lo;

  always_ff @(posedge clk_i)
  begin
    lo_lo_r <= lo_lo_n;
    cross_r <= cross_n;
  end

  assign data_o = lo_lo_r + {cross_r, {half_lp{1'b0}}};

endmodule

//--- verilog/calc_completion.sv
// **************************************************
// Completion pipe with per-stage result merge
// Integer results land in stage 0, products in
// stage 1; writeback and commit come from stage 1
// A flush poisons everything entering either stage
// **************************************************
`timescale 1ns/10ps

module calc_completion
  #(parameter data_width_p = 64)
  (input                                                    clk_i
  , input                                                  rst_n_i
  , input                                                  flush_i
  , input                                                  res_v_i
  , input                                                  res_int_v_i
  , input                                                  res_mul_v_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]               res_rd_addr_i
  , input                                                  res_w_v_i
  , input                                                  res_poison_i
  , input  [data_width_p-1:0]                              int_data_i
  , input  [data_width_p-1:0]                              mul_data_i
  , output logic [calc_pkg::fwd_els_gp-1:0]                fwd_w_v_o
  , output logic [calc_pkg::fwd_els_gp-1:0][calc_pkg::reg_addr_width_gp-1:0] fwd_rd_addr_o
  , output logic [calc_pkg::fwd_els_gp-1:0][data_width_p-1:0] fwd_data_o
  , output                                                 wb_v_o
  , output [calc_pkg::reg_addr_width_gp-1:0]               wb_rd_addr_o
  , output [data_width_p-1:0]                              wb_data_o
  , output                                                 commit_v_o
  );

  import calc_pkg::*;

  localparam int last_lp = pipe_stage_els_gp - 1;

  logic [pipe_stage_els_gp-1:0]                        stg_v_r;
  logic [pipe_stage_els_gp-1:0]                        stg_v_n;
  logic [pipe_stage_els_gp-1:0]                        stg_w_v_r;
  logic [pipe_stage_els_gp-1:0]                        stg_w_v_n;
  logic [pipe_stage_els_gp-1:0]                        stg_poison_r;
  logic [pipe_stage_els_gp-1:0]                        stg_poison_n;
  logic [pipe_stage_els_gp-1:0][reg_addr_width_gp-1:0] stg_rd_r;
  logic [pipe_stage_els_gp-1:0][reg_addr_width_gp-1:0] stg_rd_n;
  logic [pipe_stage_els_gp-1:0][data_width_p-1:0]      stg_data_r;
  logic [pipe_stage_els_gp-1:0][data_width_p-1:0]      stg_data_n;
  // Stage 0 entry still waits for its product
  logic                                                s0_mul_r;

  always_comb
  begin
    stg_v_n[0]      = res_v_i;
    stg_w_v_n[0]    = res_w_v_i;
    stg_poison_n[0] = res_poison_i | flush_i;
    stg_rd_n[0]     = res_rd_addr_i;
    stg_data_n[0]   = '0;
    // Everything else shifts down one stage
    for (int i = 1; i < pipe_stage_els_gp; i++)
    begin
      stg_v_n[i]      = stg_v_r[i-1];
      stg_w_v_n[i]    = stg_w_v_r[i-1];
      stg_poison_n[i] = stg_poison_r[i-1] | flush_i;
      stg_rd_n[i]     = stg_rd_r[i-1];
      stg_data_n[i]   = stg_data_r[i-1];
    end
    // With static latencies the two merges never collide on one stage
    if (res_int_v_i)
      stg_data_n[int_comp_idx_gp] = int_data_i;
    if (s0_mul_r)
      stg_data_n[mul_comp_idx_gp] = mul_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      stg_v_r      <= '0;
      stg_poison_r <= '0;
      s0_mul_r     <= 1'b0;
    end
    else
    begin
      stg_v_r      <= stg_v_n;
      stg_poison_r <= stg_poison_n;
      s0_mul_r     <= res_mul_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    stg_w_v_r  <= stg_w_v_n;
    stg_rd_r   <= stg_rd_n;
    stg_data_r <= stg_data_n;
  end

  // Youngest first
  always_comb
  begin
    fwd_w_v_o[0]     = res_int_v_i & res_w_v_i & ~stg_poison_n[0];
    fwd_rd_addr_o[0] = res_rd_addr_i;
    fwd_data_o[0]    = int_data_i;

    fwd_w_v_o[1]     = stg_v_n[last_lp] & stg_w_v_n[last_lp] & ~stg_poison_n[last_lp];
    fwd_rd_addr_o[1] = stg_rd_n[last_lp];
    fwd_data_o[1]    = stg_data_n[last_lp];

    // Register file picks this up only at the next edge
    fwd_w_v_o[2]     = stg_v_r[last_lp] & stg_w_v_r[last_lp] & ~stg_poison_r[last_lp];
    fwd_rd_addr_o[2] = stg_rd_r[last_lp];
    fwd_data_o[2]    = stg_data_r[last_lp];
  end

  assign commit_v_o   = stg_v_r[last_lp] & ~stg_poison_r[last_lp];
  assign wb_v_o       = commit_v_o & stg_w_v_r[last_lp];
  assign wb_rd_addr_o = stg_rd_r[last_lp];
  assign wb_data_o    = stg_data_r[last_lp];

endmodule

//--- verilog/calc_top.sv
// **************************************************
// Execution calculator top, single issue
// Writeback two cycles after dispatch for all ops
// No back-pressure so the pipe always advances
// Do not dispatch a reader of a multiply directly
// after that multiply
// **************************************************
`timescale 1ns/10ps

module calc_top
  #(parameter data_width_p = 64)
  (input                                       clk_i
  , input                                     rst_n_i
  , input                                     dispatch_v_i
  , input                                     poison_i
  , input                                     flush_i
  , input  calc_pkg::calc_op_e                fu_op_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]  rs1_addr_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]  rs2_addr_i
  , input  [calc_pkg::reg_addr_width_gp-1:0]  rd_addr_i
  , input  [data_width_p-1:0]                 rs1_data_i
  , input  [data_width_p-1:0]                 rs2_data_i
  , input  [data_width_p-1:0]                 imm_i
  , input                                     use_imm_i
  , input                                     irf_w_v_i
  , output                                    wb_v_o
  , output [calc_pkg::reg_addr_width_gp-1:0]  wb_rd_addr_o
  , output [data_width_p-1:0]                 wb_data_o
  , output                                    commit_v_o
  , output                                    ex1_v_o
  );

  import calc_pkg::*;

  // Reservation register outputs
  logic                         res_v;
  logic                         res_int_v;
  logic                         res_mul_v;
  calc_op_e                     res_op;
  logic [data_width_p-1:0]      res_rs1;
  logic [data_width_p-1:0]      res_rs2;
  logic [reg_addr_width_gp-1:0] res_rd_addr;
  logic                         res_w_v;
  logic                         res_poison;

  logic [data_width_p-1:0]      int_data;
  logic [data_width_p-1:0]      mul_data;

  // Forwarding network back to issue
  logic [fwd_els_gp-1:0]                        fwd_w_v;
  logic [fwd_els_gp-1:0][reg_addr_width_gp-1:0] fwd_rd_addr;
  logic [fwd_els_gp-1:0][data_width_p-1:0]      fwd_data;

  calc_issue
   #(.data_width_p(data_width_p))
   issue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.poison_i(poison_i)
     ,.flush_i(flush_i)
     ,.fu_op_i(fu_op_i)
     ,.rs1_addr_i(rs1_addr_i)
     ,.rs2_addr_i(rs2_addr_i)
     ,.rd_addr_i(rd_addr_i)
     ,.rs1_data_i(rs1_data_i)
     ,.rs2_data_i(rs2_data_i)
     ,.imm_i(imm_i)
     ,.use_imm_i(use_imm_i)
     ,.irf_w_v_i(irf_w_v_i)
     ,.fwd_w_v_i(fwd_w_v)
     ,.fwd_rd_addr_i(fwd_rd_addr)
     ,.fwd_data_i(fwd_data)
     ,.res_v_o(res_v)
     ,.res_int_v_o(res_int_v)
     ,.res_mul_v_o(res_mul_v)
     ,.res_op_o(res_op)
     ,.res_rs1_o(res_rs1)
     ,.res_rs2_o(res_rs2)
     ,.res_rd_addr_o(res_rd_addr)
     ,.res_w_v_o(res_w_v)
     ,.res_poison_o(res_poison)
     ,.ex1_v_o(ex1_v_o)
     );

  // Integer pipe with its result during EX1
  calc_pipe_int
   #(.data_width_p(data_width_p))
   pipe_int
    (.op_i(res_op)
     ,.rs1_i(res_rs1)
     ,.rs2_i(res_rs2)
     ,.data_o(int_data)
     );

  // Multiply pipe with its result one cycle after EX1
  calc_pipe_mul
   #(.data_width_p(data_width_p))
   pipe_mul
    (.clk_i(clk_i)
     ,.rs1_i(res_rs1)
     ,.rs2_i(res_rs2)
     ,.data_o(mul_data)
     );

  calc_completion
   #(.data_width_p(data_width_p))
   completion
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.flush_i(flush_i)
     ,.res_v_i(res_v)
     ,.res_int_v_i(res_int_v)
     ,.res_mul_v_i(res_mul_v)
     ,.res_rd_addr_i(res_rd_addr)
     ,.res_w_v_i(res_w_v)
     ,.res_poison_i(res_poison)
     ,.int_data_i(int_data)
     ,.mul_data_i(mul_data)
     ,.fwd_w_v_o(fwd_w_v)
     ,.fwd_rd_addr_o(fwd_rd_addr)
     ,.fwd_data_o(fwd_data)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_addr_o(wb_rd_addr_o)
     ,.wb_data_o(wb_data_o)
     ,.commit_v_o(commit_v_o)
     );

endmodule

//--- include/calc_tb_tasks.svh
// **************************************************
// Testbench helpers, included inside the testbench
// module and using its signals and models directly
// Expected values follow the ALU and multiply rules
// for a 64-bit data path
// **************************************************

`ifndef CALC_TB_TASKS_SVH
`define CALC_TB_TASKS_SVH

// Expected result of one operation
function automatic logic [63:0] ref_result(input calc_op_e op, input logic [63:0] a,
                                           input logic [63:0] b);
  logic [5:0] sh;
  sh = b[5:0];
  case (op)
    e_op_add:  return a + b;
    e_op_sub:  return a - b;
    e_op_and:  return a & b;
    e_op_or:   return a | b;
    e_op_xor:  return a ^ b;
    e_op_sll:  return a << sh;
    e_op_srl:  return a >> sh;
    e_op_sra:  return $signed(a) >>> sh;
    e_op_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    e_op_sltu: return (a < b) ? 64'd1 : 64'd0;
    e_op_mul:  return a * b;
    default:   return 64'd0;
  endcase
endfunction

task automatic compare(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
  if (actual !== expected)
  begin
    errors++;
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
  end
endtask

// One dispatch where dead marks an instruction that a flush or poison kills
task automatic issue_op(input calc_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic use_imm, input logic [63:0] imm,
                        input logic dead, input logic poison, input logic flush);
  logic [63:0] b;
  logic [63:0] res;
  int          slot;
  @(negedge clk_i);
  dispatch_v_i = 1'b1;
  poison_i     = poison;
  flush_i      = flush;
  fu_op_i      = op;
  rs1_addr_i   = rs1;
  rs2_addr_i   = rs2;
  rd_addr_i    = rd;
  // Possibly stale operands with x0 reading zero
  rs1_data_i   = rf[rs1];
  rs2_data_i   = rf[rs2];
  imm_i        = imm;
  use_imm_i    = use_imm;
  irf_w_v_i    = 1'b1;

  b    = use_imm ? imm : arch[rs2];
  res  = ref_result(op, arch[rs1], b);
  slot = (cyc + 3) % 8;
  exp_commit[slot] = !dead;
  exp_wb_v[slot]   = !dead && (rd != 5'd0);
  exp_rd[slot]     = rd;
  exp_data[slot]   = res;
  // In EX1 during the next cycle unless killed at dispatch
  exp_ex1[(cyc + 1) % 8] = !poison && !flush;
  if (!dead && (rd != 5'd0))
    arch[rd] = res;
  // The two older instructions still in flight die too
  if (flush)
  begin
    exp_commit[(cyc + 1) % 8] = 1'b0;
    exp_wb_v[(cyc + 1) % 8]   = 1'b0;
    exp_commit[(cyc + 2) % 8] = 1'b0;
    exp_wb_v[(cyc + 2) % 8]   = 1'b0;
    // The previous dispatch leaves EX1 in this cycle
    exp_ex1[cyc % 8]          = 1'b0;
  end
endtask

task automatic idle(input int n);
  repeat (n)
  begin
    @(negedge clk_i);
    dispatch_v_i = 1'b0;
    poison_i     = 1'b0;
    flush_i      = 1'b0;
  end
endtask

`endif

//--- bench/calc_tb.sv
// **************************************************
// Testbench for the execution calculator
// Models the register file and an in-order reference
// state and expects writeback two cycles after dispatch
// Never dispatches a reader of a multiply in the
// cycle right after that multiply
// **************************************************
`timescale 1ns/10ps

module calc_tb;

  import calc_pkg::*;

  localparam int width_lp      = 64;
  localparam int max_cycles_lp = 400;

  logic                         clk_i = 1'b0;
  logic                         rst_n_i;
  logic                         dispatch_v_i;
  logic                         poison_i;
  logic                         flush_i;
  calc_op_e                     fu_op_i;
  logic [reg_addr_width_gp-1:0] rs1_addr_i;
  logic [reg_addr_width_gp-1:0] rs2_addr_i;
  logic [reg_addr_width_gp-1:0] rd_addr_i;
  logic [width_lp-1:0]          rs1_data_i;
  logic [width_lp-1:0]          rs2_data_i;
  logic [width_lp-1:0]          imm_i;
  logic                         use_imm_i;
  logic                         irf_w_v_i;
  logic                         wb_v_o;
  logic [reg_addr_width_gp-1:0] wb_rd_addr_o;
  logic [width_lp-1:0]          wb_data_o;
  logic                         commit_v_o;
  logic                         ex1_v_o;

  // Register file that only writeback updates
  logic [width_lp-1:0] rf [0:31];
  // Reference state updated in dispatch order
  logic [width_lp-1:0] arch [0:31];

  // Expected writeback indexed by cycle modulo 8
  logic                         exp_wb_v   [0:7];
  logic                         exp_commit [0:7];
  logic [reg_addr_width_gp-1:0] exp_rd     [0:7];
  logic [width_lp-1:0]          exp_data   [0:7];
  // Expected EX1 valid indexed the same way
  logic                         exp_ex1    [0:7];

  int cyc;
  int errors;
  int mon_slot;
  int seed_val;

  calc_top
   #(.data_width_p(width_lp))
   UUT
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.poison_i(poison_i)
     ,.flush_i(flush_i)
     ,.fu_op_i(fu_op_i)
     ,.rs1_addr_i(rs1_addr_i)
     ,.rs2_addr_i(rs2_addr_i)
     ,.rd_addr_i(rd_addr_i)
     ,.rs1_data_i(rs1_data_i)
     ,.rs2_data_i(rs2_data_i)
     ,.imm_i(imm_i)
     ,.use_imm_i(use_imm_i)
     ,.irf_w_v_i(irf_w_v_i)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_addr_o(wb_rd_addr_o)
     ,.wb_data_o(wb_data_o)
     ,.commit_v_o(commit_v_o)
     ,.ex1_v_o(ex1_v_o)
     );

  `include "calc_tb_tasks.svh"

  always #5 clk_i = ~clk_i;

  // Cycle count and run limit
  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles_lp)
    begin
      $display("Timeout: the test sequence did not finish within %0d cycles", max_cycles_lp);
      $display("Done: errors found");
      $finish;
    end
  end

  // Register file write at the end of a writeback cycle
  always @(posedge clk_i)
  begin
    if (rst_n_i && wb_v_o && (wb_rd_addr_o != '0))
      rf[wb_rd_addr_o] <= wb_data_o;
  end

  // Writeback monitor sampling mid-cycle after reset
  always @(negedge clk_i)
  begin
    if (cyc >= 5)
    begin
      mon_slot = cyc % 8;
      compare("wb_v_o", wb_v_o, exp_wb_v[mon_slot]);
      compare("commit_v_o", commit_v_o, exp_commit[mon_slot]);
      if (exp_wb_v[mon_slot])
      begin
        compare("wb_rd_addr_o", wb_rd_addr_o, exp_rd[mon_slot]);
        compare("wb_data_o", wb_data_o, exp_data[mon_slot]);
      end
      exp_wb_v[mon_slot]   = 1'b0;
      exp_commit[mon_slot] = 1'b0;
    end
  end

  // EX1 valid sampled just before the edge that ends the cycle
  always @(posedge clk_i)
  begin
    if (cyc >= 5)
    begin
      compare("ex1_v_o", ex1_v_o, exp_ex1[cyc % 8]);
      exp_ex1[cyc % 8] = 1'b0;
    end
  end

  task automatic check_reset_state();
    @(negedge clk_i);
    compare("wb_v_o", wb_v_o, 1'b0);
    compare("commit_v_o", commit_v_o, 1'b0);
    compare("ex1_v_o", ex1_v_o, 1'b0);
  endtask

  // Sources in x1..x15 and destinations in x16..x31 or x0
  task automatic random_alu_ops();
    logic [3:0]  code;
    logic [4:0]  rd;
    logic [63:0] imm;
    for (int i = 0; i < 40; i++)
    begin
      code = 4'($urandom_range(0, 9));
      rd   = (i % 10 == 3) ? 5'd0 : 5'($urandom_range(16, 31));
      imm  = {$urandom, $urandom};
      issue_op(calc_op_e'(code), rd, 5'($urandom_range(1, 15)),
               5'($urandom_range(1, 15)), 1'($urandom_range(0, 1)), imm,
               1'b0, 1'b0, 1'b0);
    end
    idle(3);
  endtask

  task automatic forward_chain();
    logic [3:0] code;
    issue_op(e_op_add, 5'd20, 5'd1, 5'd2, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    // Readers of x20 at distances of one to four
    issue_op(e_op_sub, 5'd21, 5'd20, 5'd3, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_xor, 5'd22, 5'd20, 5'd21, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_or, 5'd23, 5'd20, 5'd22, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_and, 5'd24, 5'd20, 5'd23, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    // Two in-flight writers of x20 where the youngest must win
    issue_op(e_op_add, 5'd20, 5'd20, 5'd0, 1'b1, 64'h11, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_sll, 5'd20, 5'd20, 5'd0, 1'b1, 64'd3, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd21, 5'd20, 5'd24, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 10; i++)
    begin
      code = 4'($urandom_range(0, 9));
      issue_op(calc_op_e'(code), 5'(25 + i % 3), 5'(25 + (i + 2) % 3),
               5'(25 + (i + 1) % 3), 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    end
    idle(3);
  endtask

  task automatic mul_interleave();
    issue_op(e_op_mul, 5'd10, 5'd1, 5'd2, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd11, 5'd3, 5'd4, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    // Product of x10 arrives after a one-instruction gap
    issue_op(e_op_mul, 5'd12, 5'd10, 5'd5, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_sub, 5'd13, 5'd11, 5'd6, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd14, 5'd12, 5'd10, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_mul, 5'd15, 5'd13, 5'd0, 1'b1, 64'h1234_5678_9abc, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_mul, 5'd16, 5'd14, 5'd14, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd17, 5'd15, 5'd1, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    idle(3);
  endtask

  task automatic flush_and_poison();
    issue_op(e_op_add, 5'd5, 5'd1, 5'd2, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    // Flush on the third of these kills all three
    issue_op(e_op_add, 5'd6, 5'd1, 5'd3, 1'b0, 64'd0, 1'b1, 1'b0, 1'b0);
    issue_op(e_op_sub, 5'd7, 5'd6, 5'd1, 1'b0, 64'd0, 1'b1, 1'b0, 1'b0);
    issue_op(e_op_xor, 5'd8, 5'd1, 5'd2, 1'b0, 64'd0, 1'b1, 1'b0, 1'b1);
    issue_op(e_op_add, 5'd9, 5'd6, 5'd5, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd6, 5'd2, 5'd3, 1'b0, 64'd0, 1'b1, 1'b1, 1'b0);
    issue_op(e_op_or, 5'd10, 5'd6, 5'd7, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    issue_op(e_op_add, 5'd11, 5'd9, 5'd8, 1'b0, 64'd0, 1'b0, 1'b0, 1'b0);
    idle(4);
  endtask

  initial
  begin
    seed_val     = $urandom(32'h50292382);
    cyc          = 0;
    errors       = 0;
    rst_n_i      = 1'b0;
    dispatch_v_i = 1'b0;
    poison_i     = 1'b0;
    flush_i      = 1'b0;
    fu_op_i      = e_op_add;
    rs1_addr_i   = '0;
    rs2_addr_i   = '0;
    rd_addr_i    = '0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    imm_i        = '0;
    use_imm_i    = 1'b0;
    irf_w_v_i    = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      exp_wb_v[i]   = 1'b0;
      exp_commit[i] = 1'b0;
      exp_rd[i]     = '0;
      exp_data[i]   = '0;
      exp_ex1[i]    = 1'b0;
    end
    rf[0]   = '0;
    arch[0] = '0;
    for (int i = 1; i < 32; i++)
    begin
      rf[i]   = {$urandom, $urandom};
      arch[i] = rf[i];
    end

    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    check_reset_state();
    random_alu_ops();
    forward_chain();
    mul_interleave();
    flush_and_poison();

    $display("Checks failed: %0d", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
verilog/calc_pkg.sv
verilog/calc_issue.sv
verilog/calc_pipe_int.sv
verilog/calc_pipe_mul.sv
verilog/calc_completion.sv
verilog/calc_top.sv
bench/calc_tb.sv

//--- Bender.yml
package:
  name: calc

sources:
  - files:
      - verilog/calc_pkg.sv
      - verilog/calc_issue.sv
      - verilog/calc_pipe_int.sv
      - verilog/calc_pipe_mul.sv
      - verilog/calc_completion.sv
      - verilog/calc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/calc_tb.sv
